/* project.f */
hw/video_read_pkg.sv
hw/frame_reader.sv
hw/line_fifo.sv
hw/axi_read_arbiter.sv
hw/video_read_top.sv
dv/tb_video_read.sv

/* Makefile */
TOP = tb_video_read

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^\*\*\* PASSED \*\*\*$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/tb_video_read.sv */
`timescale 1ns/1ps

module tb_video_read;
	import video_read_pkg::*;

	localparam int NUM_CH = 2;
	localparam int BURST_LEN = 4;
	localparam int FIFO_AW = 4;
	localparam int ID_W = 1;

	// 16x4 pixel test image of four words per row
	localparam int IMG_W = 16;
	localparam int IMG_H = 4;
	localparam int WORDS_PER_ROW = IMG_W / PIXELS_PER_WORD;
	localparam int FRAME_WORDS = WORDS_PER_ROW * IMG_H;
	localparam logic [AXI_ADDR_W-1:0] BASE0 = 32'h1000_0000;
	localparam logic [AXI_ADDR_W-1:0] BASE1 = 32'h2000_0400;
	localparam int TIMEOUT = 500;
	localparam int HOLD_CYCLES = 80;

	logic M_AXI_ACLK;
	logic M_AXI_ARESETN;
	logic [NUM_CH-1:0] soft_resetn;
	logic [NUM_CH-1:0] resetting;
	logic [NUM_CH-1:0] fsync;
	logic [NUM_CH-1:0] frame_pulse;
	logic [NUM_CH*AXI_ADDR_W-1:0] base_addr;
	logic [NUM_CH*IMG_W_BITS-1:0] img_width;
	logic [NUM_CH*IMG_H_BITS-1:0] img_height;
	logic [NUM_CH-1:0] err;
	logic [NUM_CH-1:0] rd_en;
	logic [NUM_CH-1:0] m_valid;
	logic [NUM_CH*AXI_DATA_W-1:0] m_data;
	logic [NUM_CH-1:0] m_sof;
	logic [NUM_CH-1:0] m_eol;
	logic [ID_W-1:0] M_AXI_ARID;
	logic [AXI_ADDR_W-1:0] M_AXI_ARADDR;
	logic [7:0] M_AXI_ARLEN;
	logic [2:0] M_AXI_ARSIZE;
	logic [1:0] M_AXI_ARBURST;
	logic M_AXI_ARVALID;
	logic M_AXI_ARREADY;
	logic [ID_W-1:0] M_AXI_RID;
	logic [AXI_DATA_W-1:0] M_AXI_RDATA;
	logic [1:0] M_AXI_RRESP;
	logic M_AXI_RLAST;
	logic M_AXI_RVALID;
	logic M_AXI_RREADY;

	int checks;
	int errors;
	int timeouts;
	// Channel whose next beat gets an error response
	int inject_ch = -1;
	int ar_count [NUM_CH];

	video_read_top #(
		.NUM_CH(NUM_CH),
		.BURST_LEN(BURST_LEN),
		.FIFO_AW(FIFO_AW),
		.ID_W(ID_W)
	) dut0 (.*);

	initial begin
		M_AXI_ACLK = 1'b0;
		forever #5 M_AXI_ACLK = ~M_AXI_ACLK;
	end

	// Accepted AR requests per channel
	always @(posedge M_AXI_ACLK) begin
		if (M_AXI_ARVALID && M_AXI_ARREADY)
			ar_count[M_AXI_ARID] <= ar_count[M_AXI_ARID] + 1;
	end

	// ------------------------------
	// Report helpers
	// ------------------------------
	task automatic finish_run();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t while waiting for %s", $time, what);
		timeouts++;
		finish_run();
	endtask

	function automatic logic [AXI_ADDR_W-1:0] channel_base(input int ch);
		return (ch == 0) ? BASE0 : BASE1;
	endfunction

	// Expected word follows from base, word index and row length
	task automatic check_word(input int ch, input int idx, input logic [AXI_DATA_W-1:0] data,
			input logic sof, input logic eol);
		logic [AXI_DATA_W-1:0] exp_data;
		logic exp_sof;
		logic exp_eol;
		exp_data = channel_base(ch) + AXI_ADDR_W'(idx * BYTES_PER_WORD);
		exp_sof = (idx == 0);
		exp_eol = ((idx + 1) % WORDS_PER_ROW) == 0;
		checks++;
		if (data !== exp_data || sof !== exp_sof || eol !== exp_eol) begin
			$display("error %0t: ch%0d word %0d is %h sof %b eol %b, expected %h sof %b eol %b",
				$time, ch, idx, data, sof, eol, exp_data, exp_sof, exp_eol);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input int ch, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("error %0t: ch%0d %s is %b, expected %b", $time, ch, what, got, exp);
			errors++;
		end
	endtask

	// Full-word INCR burst of BURST_LEN beats
	task automatic check_ar(input logic [7:0] len, input logic [2:0] size,
			input logic [1:0] burst);
		logic [7:0] exp_len;
		logic [2:0] exp_size;
		logic [1:0] exp_burst;
		exp_len = 8'(BURST_LEN - 1);
		exp_size = 3'($clog2(BYTES_PER_WORD));
		exp_burst = 2'b01;
		checks++;
		if (len !== exp_len || size !== exp_size || burst !== exp_burst) begin
			$display("error %0t: AR len %0d size %0d burst %b, expected len %0d size %0d burst %b",
				$time, len, size, burst, exp_len, exp_size, exp_burst);
			errors++;
		end
	endtask

	// ------------------------------
	// Stimulus and wait tasks
	// ------------------------------
	task automatic start_frames(input logic [NUM_CH-1:0] mask);
		@(posedge M_AXI_ACLK);
		#1;
		fsync = mask;
		@(negedge M_AXI_ACLK);
		for (int ch = 0; ch < NUM_CH; ch++)
			if (mask[ch])
				check_flag("frame_pulse", ch, frame_pulse[ch], 1'b1);
		@(posedge M_AXI_ACLK);
		#1;
		fsync = '0;
	endtask

	// Pops one word per cycle whenever one is ready
	task automatic read_words(input int ch, input int first, input int num);
		int idx;
		int cyc;
		idx = first;
		cyc = 0;
		while (idx < first + num) begin
			@(posedge M_AXI_ACLK);
			#1;
			rd_en[ch] = 1'b0;
			if (m_valid[ch]) begin
				check_word(ch, idx, m_data[ch*AXI_DATA_W +: AXI_DATA_W], m_sof[ch], m_eol[ch]);
				rd_en[ch] = 1'b1;
				idx++;
				cyc = 0;
			end else begin
				cyc++;
				if (cyc > TIMEOUT)
					report_timeout("a FIFO word");
			end
		end
		@(posedge M_AXI_ACLK);
		#1;
		rd_en[ch] = 1'b0;
	endtask

	// Discard words until the FIFO stays empty for a while
	task automatic drain_fifo(input int ch);
		int quiet;
		int cyc;
		quiet = 0;
		cyc = 0;
		while (quiet < 8) begin
			@(posedge M_AXI_ACLK);
			#1;
			rd_en[ch] = m_valid[ch];
			quiet = m_valid[ch] ? 0 : quiet + 1;
			cyc++;
			if (cyc > TIMEOUT)
				report_timeout("the FIFO to drain");
		end
	endtask

	task automatic wait_resetting(input int ch, input logic level);
		int cyc;
		cyc = 0;
		@(negedge M_AXI_ACLK);
		while (resetting[ch] !== level) begin
			cyc++;
			if (cyc > TIMEOUT)
				report_timeout("resetting to change");
			@(negedge M_AXI_ACLK);
		end
	endtask

	// ------------------------------
	// AXI memory model
	// ------------------------------
	initial begin : memory_model
		logic [AXI_ADDR_W-1:0] addr;
		logic [ID_W-1:0] id;
		logic err_done;
		logic ready_seen;
		int wait_cyc;
		int stall;
		void'($urandom(32'h36be660f));
		M_AXI_ARREADY = 1'b0;
		M_AXI_RID = '0;
		M_AXI_RDATA = '0;
		M_AXI_RRESP = 2'b00;
		M_AXI_RLAST = 1'b0;
		M_AXI_RVALID = 1'b0;
		err_done = 1'b0;
		forever begin
			@(posedge M_AXI_ACLK);
			#1;
			if (M_AXI_ARVALID) begin
				addr = M_AXI_ARADDR;
				id = M_AXI_ARID;
				check_ar(M_AXI_ARLEN, M_AXI_ARSIZE, M_AXI_ARBURST);
				M_AXI_ARREADY = 1'b1;
				@(posedge M_AXI_ACLK);
				#1;
				M_AXI_ARREADY = 1'b0;
				wait_cyc = $urandom_range(3, 0);
				repeat (wait_cyc) begin
					@(posedge M_AXI_ACLK);
					#1;
				end
				for (int b = 0; b < BURST_LEN; b++) begin
					M_AXI_RVALID = 1'b0;
					wait_cyc = $urandom_range(2, 0);
					repeat (wait_cyc) begin
						@(posedge M_AXI_ACLK);
						#1;
					end
					M_AXI_RVALID = 1'b1;
					M_AXI_RID = id;
					M_AXI_RDATA = addr + AXI_ADDR_W'(b * BYTES_PER_WORD);
					M_AXI_RLAST = (b == BURST_LEN - 1);
					M_AXI_RRESP = 2'b00;
					if (!err_done && inject_ch == int'(id)) begin
						M_AXI_RRESP = 2'b10;
						err_done = 1'b1;
					end
					ready_seen = 1'b0;
					stall = 0;
					while (!ready_seen) begin
						@(negedge M_AXI_ACLK);
						ready_seen = M_AXI_RREADY;
						@(posedge M_AXI_ACLK);
						#1;
						stall++;
						if (stall > TIMEOUT)
							report_timeout("RREADY");
					end
				end
				M_AXI_RVALID = 1'b0;
				M_AXI_RLAST = 1'b0;
				M_AXI_RRESP = 2'b00;
			end
		end
	end

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic check_reset_state();
		@(negedge M_AXI_ACLK);
		check_flag("ARVALID", 0, M_AXI_ARVALID, 1'b0);
		check_flag("RREADY", 0, M_AXI_RREADY, 1'b0);
		for (int ch = 0; ch < NUM_CH; ch++) begin
			check_flag("m_valid", ch, m_valid[ch], 1'b0);
			check_flag("err", ch, err[ch], 1'b0);
			check_flag("resetting", ch, resetting[ch], 1'b1);
		end
		for (int ch = 0; ch < NUM_CH; ch++)
			wait_resetting(ch, 1'b0);
	endtask

	task automatic test_single_frame();
		start_frames(2'b01);
		read_words(0, 0, FRAME_WORDS);
	endtask

	task automatic test_dual_frames();
		start_frames(2'b11);
		fork
			read_words(0, 0, FRAME_WORDS);
			read_words(1, 0, FRAME_WORDS);
		join
	endtask

	task automatic test_back_pressure();
		int bursts_before;
		bursts_before = ar_count[0];
		start_frames(2'b01);
		repeat (HOLD_CYCLES) @(posedge M_AXI_ACLK);
		@(negedge M_AXI_ACLK);
		// One burst fills the FIFO up to the start threshold
		check_flag("one burst while stalled", 0, (ar_count[0] - bursts_before) == 1, 1'b1);
		check_flag("m_valid while stalled", 0, m_valid[0], 1'b1);
		read_words(0, 0, FRAME_WORDS);
	endtask

	task automatic test_back_to_back();
		start_frames(2'b10);
		read_words(1, 0, FRAME_WORDS);
		start_frames(2'b10);
		read_words(1, 0, FRAME_WORDS);
	endtask

	task automatic test_soft_reset();
		start_frames(2'b01);
		read_words(0, 0, 6);
		@(posedge M_AXI_ACLK);
		#1;
		soft_resetn[0] = 1'b0;
		wait_resetting(0, 1'b1);
		wait_resetting(0, 1'b0);
		@(posedge M_AXI_ACLK);
		#1;
		soft_resetn[0] = 1'b1;
		// Words left from the aborted frame
		drain_fifo(0);
		start_frames(2'b01);
		read_words(0, 0, FRAME_WORDS);
	endtask

	task automatic test_slave_error();
		inject_ch = 1;
		start_frames(2'b10);
		read_words(1, 0, FRAME_WORDS);
		@(negedge M_AXI_ACLK);
		check_flag("err", 1, err[1], 1'b1);
		check_flag("err", 0, err[0], 1'b0);
	endtask

	initial begin
		M_AXI_ARESETN = 1'b0;
		soft_resetn = '1;
		fsync = '0;
		rd_en = '0;
		base_addr = {BASE1, BASE0};
		img_width = {NUM_CH{IMG_W_BITS'(IMG_W)}};
		img_height = {NUM_CH{IMG_H_BITS'(IMG_H)}};
		repeat (3) @(posedge M_AXI_ACLK);
		#1;
		M_AXI_ARESETN = 1'b1;
		check_reset_state();
		test_single_frame();
		test_dual_frames();
		test_back_pressure();
		test_back_to_back();
		test_soft_reset();
		// err is sticky, so this runs last
		test_slave_error();
		finish_run();
	end

endmodule

/* hw/video_read_top.sv */
`timescale 1ns/1ps

module video_read_top #(
	parameter int NUM_CH = 2,
	parameter int BURST_LEN = 4,
	parameter int FIFO_AW = 4,
	parameter int ID_W = 1
) (
	input  logic M_AXI_ACLK,
	input  logic M_AXI_ARESETN,
	input  logic [NUM_CH-1:0] soft_resetn,
	output logic [NUM_CH-1:0] resetting,
	input  logic [NUM_CH-1:0] fsync,
	output logic [NUM_CH-1:0] frame_pulse,
	input  logic [NUM_CH*video_read_pkg::AXI_ADDR_W-1:0] base_addr,
	input  logic [NUM_CH*video_read_pkg::IMG_W_BITS-1:0] img_width,
	input  logic [NUM_CH*video_read_pkg::IMG_H_BITS-1:0] img_height,
	output logic [NUM_CH-1:0] err,
	input  logic [NUM_CH-1:0] rd_en,
	output logic [NUM_CH-1:0] m_valid,
	output logic [NUM_CH*video_read_pkg::AXI_DATA_W-1:0] m_data,
	output logic [NUM_CH-1:0] m_sof,
	output logic [NUM_CH-1:0] m_eol,
	output logic [ID_W-1:0] M_AXI_ARID,
	output logic [video_read_pkg::AXI_ADDR_W-1:0] M_AXI_ARADDR,
	output logic [7:0] M_AXI_ARLEN,
	output logic [2:0] M_AXI_ARSIZE,
	output logic [1:0] M_AXI_ARBURST,
	output logic M_AXI_ARVALID,
	input  logic M_AXI_ARREADY,
	input  logic [ID_W-1:0] M_AXI_RID,
	input  logic [video_read_pkg::AXI_DATA_W-1:0] M_AXI_RDATA,
	input  logic [1:0] M_AXI_RRESP,
	input  logic M_AXI_RLAST,
	input  logic M_AXI_RVALID,
	output logic M_AXI_RREADY
);
	import video_read_pkg::*;

	// Reader side of the shared port
	logic [NUM_CH-1:0] ar_req;
	logic [NUM_CH*AXI_ADDR_W-1:0] ar_addr;
	logic [NUM_CH-1:0] ar_ack;
	logic [NUM_CH-1:0] r_valid;
	logic [NUM_CH-1:0] rready;
	logic [AXI_DATA_W-1:0] r_data;
	logic r_last;
	logic r_err;

	for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
		logic wr_en;
		logic [AXI_DATA_W-1:0] dout;
		logic sof;
		logic eol;
		logic full;
		logic [FIFO_AW:0] wr_data_count;

		frame_reader #(
			.BURST_LEN(BURST_LEN),
			.FIFO_AW(FIFO_AW)
		) u_reader (
			.M_AXI_ACLK, .M_AXI_ARESETN,
			.soft_resetn(soft_resetn[ch]), .resetting(resetting[ch]),
			.fsync(fsync[ch]), .frame_pulse(frame_pulse[ch]),
			.base_addr(base_addr[ch*AXI_ADDR_W +: AXI_ADDR_W]),
			.img_width(img_width[ch*IMG_W_BITS +: IMG_W_BITS]),
			.img_height(img_height[ch*IMG_H_BITS +: IMG_H_BITS]),
			.ar_req(ar_req[ch]), .ar_addr(ar_addr[ch*AXI_ADDR_W +: AXI_ADDR_W]),
			.ar_ack(ar_ack[ch]),
			.r_valid(r_valid[ch]), .r_data, .r_last, .r_err, .rready(rready[ch]),
			.wr_en, .dout, .sof, .eol, .full, .wr_data_count,
			.err(err[ch])
		);

		line_fifo #(
			.FIFO_AW(FIFO_AW)
		) u_fifo (
			.M_AXI_ACLK, .M_AXI_ARESETN,
			.wr_en, .din(dout), .din_sof(sof), .din_eol(eol),
			.full, .wr_data_count,
			.rd_en(rd_en[ch]), .m_valid(m_valid[ch]),
			.m_data(m_data[ch*AXI_DATA_W +: AXI_DATA_W]),
			.m_sof(m_sof[ch]), .m_eol(m_eol[ch])
		);
	end

	// All arbiter ports share their names with top-level signals
	axi_read_arbiter #(
		.NUM_CH(NUM_CH),
		.ID_W(ID_W),
		.BURST_LEN(BURST_LEN)
	) u_arb (.*);

endmodule

/* hw/axi_read_arbiter.sv */
`timescale 1ns/1ps

module axi_read_arbiter #(
	parameter int NUM_CH = 2,
	parameter int ID_W = 1,
	parameter int BURST_LEN = 4
) (
	input  logic M_AXI_ACLK,
	input  logic M_AXI_ARESETN,
	input  logic [NUM_CH-1:0] ar_req,
	input  logic [NUM_CH*video_read_pkg::AXI_ADDR_W-1:0] ar_addr,
	output logic [NUM_CH-1:0] ar_ack,
	output logic [NUM_CH-1:0] r_valid,
	output logic [video_read_pkg::AXI_DATA_W-1:0] r_data,
	output logic r_last,
	output logic r_err,
	input  logic [NUM_CH-1:0] rready,
	output logic [ID_W-1:0] M_AXI_ARID,
	output logic [video_read_pkg::AXI_ADDR_W-1:0] M_AXI_ARADDR,
	output logic [7:0] M_AXI_ARLEN,
	output logic [2:0] M_AXI_ARSIZE,
	output logic [1:0] M_AXI_ARBURST,
	output logic M_AXI_ARVALID,
	input  logic M_AXI_ARREADY,
	input  logic [ID_W-1:0] M_AXI_RID,
	input  logic [video_read_pkg::AXI_DATA_W-1:0] M_AXI_RDATA,
	input  logic [1:0] M_AXI_RRESP,
	input  logic M_AXI_RLAST,
	input  logic M_AXI_RVALID,
	output logic M_AXI_RREADY
);
	import video_read_pkg::*;

	// Channel with first priority in the next round
	logic [ID_W-1:0] rr_ptr;
	logic [ID_W-1:0] pick_ch;
	logic pick_found;
	logic rid_ok;

	assign M_AXI_ARLEN = 8'(BURST_LEN - 1);
	assign M_AXI_ARSIZE = ARSIZE_WORD;
	assign M_AXI_ARBURST = ARBURST_INCR;

	// ------------------------------
	// AR arbitration
	// ------------------------------
	always_comb begin
		int cand;
		pick_found = 1'b0;
		pick_ch = '0;
		for (int i = 0; i < NUM_CH; i++) begin
			cand = (int'(rr_ptr) + i) % NUM_CH;
			if (!pick_found && ar_req[cand]) begin
				pick_found = 1'b1;
				pick_ch = ID_W'(cand);
			end
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			M_AXI_ARVALID <= 1'b0;
			M_AXI_ARID <= '0;
			rr_ptr <= '0;
		end else if (!M_AXI_ARVALID && pick_found) begin
			M_AXI_ARVALID <= 1'b1;
			M_AXI_ARID <= pick_ch;
			rr_ptr <= (int'(pick_ch) == NUM_CH - 1) ? '0 : pick_ch + 1'b1;
		end else if (M_AXI_ARREADY) begin
			M_AXI_ARVALID <= 1'b0;
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARVALID && pick_found)
			M_AXI_ARADDR <= ar_addr[pick_ch*AXI_ADDR_W +: AXI_ADDR_W];
	end

	// ------------------------------
	// Handshake and R routing by ID
	// ------------------------------
	always_comb begin
		for (int ch = 0; ch < NUM_CH; ch++) begin
			ar_ack[ch] = M_AXI_ARVALID && M_AXI_ARREADY && (int'(M_AXI_ARID) == ch);
			r_valid[ch] = M_AXI_RVALID && (int'(M_AXI_RID) == ch);
		end
	end

	assign rid_ok = (int'(M_AXI_RID) < NUM_CH);
	assign M_AXI_RREADY = rid_ok ? rready[M_AXI_RID] : 1'b0;
	assign r_data = M_AXI_RDATA;
	assign r_last = M_AXI_RLAST;
	assign r_err = M_AXI_RRESP[RRESP_SLVERR_BIT];

	a_rid_range: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		M_AXI_RVALID |-> rid_ok);

endmodule

/* hw/line_fifo.sv */
`timescale 1ns/1ps

module line_fifo #(
	parameter int FIFO_AW = 4
) (
	input  logic M_AXI_ACLK,
	input  logic M_AXI_ARESETN,
	input  logic wr_en,
	input  logic [video_read_pkg::AXI_DATA_W-1:0] din,
	input  logic din_sof,
	input  logic din_eol,
	output logic full,
	output logic [FIFO_AW:0] wr_data_count,
	input  logic rd_en,
	output logic m_valid,
	output logic [video_read_pkg::AXI_DATA_W-1:0] m_data,
	output logic m_sof,
	output logic m_eol
);
	import video_read_pkg::*;

	localparam int DEPTH = 1 << FIFO_AW;

	// Entry is {sof, eol, data}
	logic [AXI_DATA_W+1:0] mem [DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0] count;
	logic do_wr;
	logic do_rd;

	// Top count bit is only set at DEPTH
	assign full = count[FIFO_AW];
	assign wr_data_count = count;
	assign m_valid = (count != '0);
	assign do_wr = wr_en & ~full;
	assign do_rd = rd_en & m_valid;

	// First word falls through
	assign {m_sof, m_eol, m_data} = mem[rd_ptr];

	always_ff @(posedge M_AXI_ACLK) begin
		if (do_wr)
			mem[wr_ptr] <= {din_sof, din_eol, din};
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_read_empty: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		rd_en |-> m_valid);

endmodule

/* hw/frame_reader.sv */
`timescale 1ns/1ps

module frame_reader #(
	parameter int BURST_LEN = 4,
	parameter int FIFO_AW = 4
) (
	input  logic M_AXI_ACLK,
	input  logic M_AXI_ARESETN,
	input  logic soft_resetn,
	output logic resetting,
	input  logic fsync,
	output logic frame_pulse,
	input  logic [video_read_pkg::AXI_ADDR_W-1:0] base_addr,
	input  logic [video_read_pkg::IMG_W_BITS-1:0] img_width,
	input  logic [video_read_pkg::IMG_H_BITS-1:0] img_height,
	output logic ar_req,
	output logic [video_read_pkg::AXI_ADDR_W-1:0] ar_addr,
	input  logic ar_ack,
	input  logic r_valid,
	input  logic [video_read_pkg::AXI_DATA_W-1:0] r_data,
	input  logic r_last,
	input  logic r_err,
	output logic rready,
	output logic wr_en,
	output logic [video_read_pkg::AXI_DATA_W-1:0] dout,
	output logic sof,
	output logic eol,
	input  logic full,
	input  logic [FIFO_AW:0] wr_data_count,
	output logic err
);
	import video_read_pkg::*;

	localparam int CNT_W = FIFO_AW + 1;
	localparam logic [CNT_W-1:0] BURST_WORDS = CNT_W'(BURST_LEN);
	localparam logic [AXI_ADDR_W-1:0] BURST_BYTES = AXI_ADDR_W'(BURST_LEN * BYTES_PER_WORD);
	localparam logic [IMG_W_BITS-1:0] PIX_STEP = IMG_W_BITS'(PIXELS_PER_WORD);

	logic soft_resetn_d1;
	logic start_pulse;
	logic burst_active;
	logic busy;
	logic rnext;
	logic in_frame;
	logic sof_pend;
	logic last_word;
	// Pixels left in the row and rows left in the frame
	logic [IMG_W_BITS-1:0] col_left;
	logic [IMG_H_BITS-1:0] row_left;

	assign busy = start_pulse | burst_active;
	assign rready = busy;
	assign rnext = r_valid & rready;
	assign last_word = (col_left == '0) && (row_left == '0);

	assign frame_pulse = ~busy & ~in_frame & fsync & soft_resetn;

	// Beats drained during a soft reset are dropped
	assign wr_en = rnext & ~resetting;
	assign dout = r_data;
	assign sof = sof_pend;
	assign eol = in_frame & (col_left == '0);

	// ------------------------------
	// Soft reset
	// ------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			soft_resetn_d1 <= 1'b0;
			resetting <= 1'b1;
		end else begin
			soft_resetn_d1 <= soft_resetn;
			if (soft_resetn_d1 && !soft_resetn)
				resetting <= 1'b1;
			else if (!busy)
				resetting <= 1'b0;
		end
	end

	// ------------------------------
	// Burst scheduling
	// ------------------------------
	// Start only when a whole burst fits in the FIFO
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			start_pulse <= 1'b0;
		else
			start_pulse <= ~busy & ~resetting & (in_frame | fsync) & soft_resetn
				& (wr_data_count < BURST_WORDS);
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			burst_active <= 1'b0;
			ar_req <= 1'b0;
		end else begin
			if (start_pulse)
				burst_active <= 1'b1;
			else if (rnext && r_last)
				burst_active <= 1'b0;
			if (start_pulse)
				ar_req <= 1'b1;
			else if (ar_ack)
				ar_req <= 1'b0;
		end
	end

	// Next burst address, back to base after the last burst of a frame
	always_ff @(posedge M_AXI_ACLK) begin
		if (start_pulse && !in_frame)
			ar_addr <= base_addr;
		else if (rnext && r_last)
			ar_addr <= last_word ? base_addr : ar_addr + BURST_BYTES;
	end

	// ------------------------------
	// Frame position
	// ------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN || resetting) begin
			col_left <= '0;
			row_left <= '0;
			in_frame <= 1'b0;
			sof_pend <= 1'b0;
		end else if (start_pulse && !in_frame) begin
			col_left <= img_width - PIX_STEP;
			row_left <= img_height - 1'b1;
			in_frame <= 1'b1;
			sof_pend <= 1'b1;
		end else if (rnext) begin
			if (col_left != '0) begin
				col_left <= col_left - PIX_STEP;
			end else if (row_left != '0) begin
				col_left <= img_width - PIX_STEP;
				row_left <= row_left - 1'b1;
			end else begin
				in_frame <= 1'b0;
			end
			sof_pend <= 1'b0;
		end
	end

	// Sticky until hard reset
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			err <= 1'b0;
		else if (rnext && r_err)
			err <= 1'b1;
	end

	a_ar_req_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		ar_req && !ar_ack |=> ar_req && $stable(ar_addr));

	a_no_write_full: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		!(wr_en && full));

endmodule

/* hw/video_read_pkg.sv */
package video_read_pkg;

	// Bus widths
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;

	// Image geometry fields
	localparam int IMG_W_BITS = 12;
	localparam int IMG_H_BITS = 12;
	// Four 8-bit pixels per data word
	localparam int PIXELS_PER_WORD = 4;
	localparam int BYTES_PER_WORD = 4;

	// AXI encodings
	localparam logic [2:0] ARSIZE_WORD = 3'b010;
	localparam logic [1:0] ARBURST_INCR = 2'b01;
	// RRESP[1] is set for both SLVERR and DECERR
	localparam int RRESP_SLVERR_BIT = 1;

endpackage
